//--- verification/ipod_testdata.txt
// Words 0-15: flash image, samples in bits 31:24 and 15:8
// Then script words: op[31:24] arg[23:0]; 01 key char, 02 buttons, 03 wait, 04 rate, 05 play, 00 end
12347F00 80119A22 3C004500 C0D15E33 05A0FA07 7011E922 2B3C8844 99AAB0CC
4D5E1F60 E1F22B13 66778899 F00F0FF0 A5A55A5A 817F7F81 10203040 DEADBEEF
03000064 01000045 03009C40 01000042 03004E20 05000001 01000044 03001388
05000000 01000052 01000045 03002710 02000006 03009C40 02000007 030007D0
040000EC 02000005 0301D4C0 02000007 030007D0 04000FC4 02000003 03000064
02000007 03000064 04000470 01000044 03000064 05000000 00000000 00000000

//--- build.f
logic/ipod_pkg.sv
logic/flash_word_if.sv
logic/key_pacer.sv
logic/rate_control.sv
logic/playback_ctrl.sv
logic/sample_fetch.sv
logic/level_meter.sv
logic/hex_display.sv
logic/ipod_top.sv
verification/ipod_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f build.f --top-module ipod_tb -o ipod_sim

./obj_dir/ipod_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
  exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
  exit 1
fi
exit 0

//--- verification/ipod_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_tb;

  // Script opcodes, upper byte of each script word
  localparam logic [7:0] OP_END = 8'h00;
  localparam logic [7:0] OP_KBD = 8'h01;
  localparam logic [7:0] OP_KEYS = 8'h02;
  localparam logic [7:0] OP_WAIT = 8'h03;
  localparam logic [7:0] OP_RATE = 8'h04;
  localparam logic [7:0] OP_PLAY = 8'h05;
  localparam int SONG_WORDS = 16;

  logic CLK_50M;
  logic arst_n;
  logic [2:0] key;
  ipod_pkg::ascii_t kbd_ascii;
  logic kbd_ready;
  logic flash_waitrequest;
  ipod_pkg::flash_word_t flash_readdata;
  logic flash_readdatavalid;
  logic flash_read;
  ipod_pkg::flash_addr_t flash_address;
  ipod_pkg::sample_t sample;
  logic sample_valid;
  logic [9:0] ledr;
  ipod_pkg::seg7_t hx [6];

  logic [31:0] tdata [0:63];
  logic [6:0] seg_tab [16];
  int value_errors = 0;
  int other_errors = 0;
  int watch_limit = 0;
  logic monitor_on = 1'b0;

  // Button history for the rate model
  logic last_dir_up = 1'b1;
  logic restore_seen = 1'b0;

  // Song wraps the model has gone through
  logic fwd_wrap_seen = 1'b0;
  logic back_wrap_seen = 1'b0;

  ipod_top DUT (
    .CLK_50M (CLK_50M),
    .arst_n (arst_n),
    .key (key),
    .kbd_ascii (kbd_ascii),
    .kbd_ready (kbd_ready),
    .flash_waitrequest (flash_waitrequest),
    .flash_readdata (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_read (flash_read),
    .flash_address (flash_address),
    .sample (sample),
    .sample_valid (sample_valid),
    .ledr (ledr),
    .hex0 (hx[0]),
    .hex1 (hx[1]),
    .hex2 (hx[2]),
    .hex3 (hx[3]),
    .hex4 (hx[4]),
    .hex5 (hx[5])
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ====================
  // Helpers
  // ====================

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  // Segment pattern back to its nibble, -1 if unknown
  function automatic int digit_value(input logic [6:0] seg);
    int found;
    found = -1;
    for (int i = 0; i < 16; i++)
      if (seg_tab[i] === seg)
        found = i;
    return found;
  endfunction

  function automatic int shown_rate();
    int val;
    int d;
    val = 0;
    for (int i = 5; i >= 0; i--)
    begin
      d = digit_value(hx[i]);
      if (d < 0)
        d = 0;
      val = val * 16 + d;
    end
    return val;
  endfunction

  task automatic check_display(input int rate);
    logic [23:0] r;
    r = 24'(rate);
    for (int i = 0; i < 6; i++)
      check_value($sformatf("hex%0d", i), {25'd0, hx[i]},
                  {25'd0, seg_tab[r[i*4 +: 4]]});
  endtask

  // LED bar expected for one sample
  function automatic logic [7:0] thermometer(input logic [7:0] s);
    logic [7:0] m;
    logic [7:0] bar;
    int n;
    m = s[7] ? (8'd0 - s) : s;
    n = int'(m >> 4);
    bar = 8'd0;
    for (int i = 0; i < n; i++)
      bar[i] = 1'b1;
    return bar;
  endfunction

  function automatic int step_addr(input int a, input logic fwd);
    if (fwd)
      return (a == SONG_WORDS - 1) ? 0 : a + 1;
    else
      return (a == 0) ? SONG_WORDS - 1 : a - 1;
  endfunction

  // ====================
  // Flash model
  // ====================

  initial
  begin
    int phase;
    int waits;
    int delay;
    int f_addr;
    ipod_pkg::flash_addr_t held_addr;
    void'($urandom(32'h58cf));
    phase = 0;
    waits = 0;
    delay = 0;
    f_addr = 0;
    held_addr = '0;
    flash_waitrequest = 1'b0;
    flash_readdata = '0;
    flash_readdatavalid = 1'b0;
    forever
    begin
      @(negedge CLK_50M);
      if (phase == 0 && flash_read === 1'b1)
      begin
        waits = int'($urandom % 4);
        delay = 1 + int'($urandom % 4);
        held_addr = flash_address;
        f_addr = int'(flash_address);
        if (f_addr >= SONG_WORDS)
        begin
          $display("ERROR at %0t: flash read beyond the song, word %0d", $time, f_addr);
          other_errors++;
          f_addr = 0;
        end
        phase = 1;
      end
      if (phase == 1)
      begin
        // Read and address hold through the wait
        check_value("flash_read", {31'd0, flash_read}, 32'd1);
        check_value("flash_address", {9'd0, flash_address}, {9'd0, held_addr});
        if (waits > 0)
        begin
          flash_waitrequest = 1'b1;
          waits--;
        end
        else
        begin
          flash_waitrequest = 1'b0;
          phase = 2;
        end
      end
      else if (phase == 2)
      begin
        // Read drops once wait is low
        check_value("flash_read", {31'd0, flash_read}, 32'd0);
        if (delay > 1)
          delay--;
        else
        begin
          flash_readdata = tdata[f_addr];
          flash_readdatavalid = 1'b1;
          phase = 3;
        end
      end
      else if (phase == 3)
      begin
        flash_readdatavalid = 1'b0;
        phase = 0;
      end
    end
  end

  // ====================
  // Monitor and model
  // ====================

  initial
  begin
    logic cap_rdy;
    ipod_pkg::ascii_t cap_asc;
    logic m_playing;
    logic m_fwd;
    logic m_half;
    int m_addr;
    int m_rate;
    int prev_rate;
    int cycle;
    int last_valid;
    int shown;
    int exp_rate;
    logic prev_valid;
    logic [7:0] prev_sample;
    logic [7:0] exp_sample;
    m_playing = 1'b0;
    m_fwd = 1'b1;
    m_half = 1'b0;
    m_addr = 0;
    m_rate = int'(ipod_pkg::RATE_DEFAULT);
    prev_rate = m_rate;
    cycle = 0;
    last_valid = -1;
    prev_valid = 1'b0;
    prev_sample = 8'd0;
    forever
    begin
      @(posedge CLK_50M);
      cap_rdy = kbd_ready;
      cap_asc = kbd_ascii;
      @(negedge CLK_50M);
      if (monitor_on)
      begin
        cycle++;
        // LED bar one cycle after each sample
        if (prev_valid)
        begin
          check_value("ledr[9:2]", {24'd0, ledr[9:2]}, {24'd0, thermometer(prev_sample)});
          check_value("ledr[1]", {31'd0, ledr[1]}, 32'd0);
        end
        prev_valid = sample_valid;
        prev_sample = sample;

        // Rate display follows paced steps
        shown = shown_rate();
        if (shown != m_rate)
        begin
          if (restore_seen)
          begin
            exp_rate = int'(ipod_pkg::RATE_DEFAULT);
            restore_seen = 1'b0;
          end
          else if (last_dir_up)
            exp_rate = (m_rate - int'(ipod_pkg::RATE_STEP) < int'(ipod_pkg::RATE_MIN)) ?
                       int'(ipod_pkg::RATE_MIN) : m_rate - int'(ipod_pkg::RATE_STEP);
          else
            exp_rate = (m_rate + int'(ipod_pkg::RATE_STEP) > int'(ipod_pkg::RATE_MAX)) ?
                       int'(ipod_pkg::RATE_MAX) : m_rate + int'(ipod_pkg::RATE_STEP);
          check_value("rate display", 32'(shown), 32'(exp_rate));
          check_display(exp_rate);
          m_rate = exp_rate;
        end

        if (sample_valid)
        begin
          if (!m_playing)
          begin
            $display("ERROR at %0t: sample_valid while playback is stopped", $time);
            other_errors++;
          end
          exp_sample = m_half ? tdata[m_addr][31:24] : tdata[m_addr][15:8];
          check_value("sample", {24'd0, sample}, {24'd0, exp_sample});
          if (last_valid >= 0 && cycle - last_valid < ((prev_rate < m_rate) ?
              prev_rate : m_rate) + 1)
          begin
            $display("ERROR at %0t: samples only %0d cycles apart", $time,
                     cycle - last_valid);
            other_errors++;
          end
          last_valid = cycle;
          prev_rate = m_rate;
          if (m_half)
          begin
            m_half = 1'b0;
            if (m_fwd && m_addr == SONG_WORDS - 1)
              fwd_wrap_seen = 1'b1;
            if (!m_fwd && m_addr == 0)
              back_wrap_seen = 1'b1;
            m_addr = step_addr(m_addr, m_fwd);
          end
          else
            m_half = 1'b1;
        end

        // Command seen by the DUT at this edge
        if (cap_rdy)
        begin
          if (cap_asc == ipod_pkg::CMD_PLAY && !m_playing)
          begin
            m_playing = 1'b1;
            m_half = 1'b0;
            last_valid = -1;
          end
          else if (cap_asc == ipod_pkg::CMD_STOP)
          begin
            m_playing = 1'b0;
            m_half = 1'b0;
          end
          else if (cap_asc == ipod_pkg::CMD_FWD)
            m_fwd = 1'b1;
          else if (cap_asc == ipod_pkg::CMD_BACK)
            m_fwd = 1'b0;
          else if (cap_asc == ipod_pkg::CMD_RESTART)
          begin
            m_addr = 0;
            m_half = 1'b0;
            last_valid = -1;
          end
        end
      end
    end
  end

  // Ends a run that stops making progress
  initial
  begin
    wait (watch_limit != 0);
    repeat (watch_limit) @(posedge CLK_50M);
    $display("ERROR: watchdog expired before the script finished");
    $display("Simulation FAILED");
    $finish;
  end

  // ====================
  // Script driver
  // ====================

  initial
  begin
    int idx;
    int total;
    logic [7:0] op;
    logic [23:0] arg;
    key = 3'b111;
    kbd_ascii = 8'h00;
    kbd_ready = 1'b0;
    arst_n = 1'b0;
    seg_tab = '{7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
                7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
                7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
                7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110};
    $readmemh("verification/ipod_testdata.txt", tdata);

    // Script length plus one song at the slowest rate
    total = 0;
    for (int i = SONG_WORDS; i < 64; i++)
      if (tdata[i][31:24] == OP_WAIT)
        total += int'(tdata[i][23:0]) + 2;
      else
        total += 3;
    watch_limit = total + 2 * SONG_WORDS * (int'(ipod_pkg::RATE_MAX) + 1) + 1000;

    repeat (16) @(negedge CLK_50M);
    arst_n = 1'b1;
    repeat (2) @(negedge CLK_50M);
    check_value("flash_read", {31'd0, flash_read}, 32'd0);
    check_value("sample_valid", {31'd0, sample_valid}, 32'd0);
    check_value("ledr", {22'd0, ledr}, 32'd0);
    check_display(int'(ipod_pkg::RATE_DEFAULT));
    monitor_on = 1'b1;

    idx = SONG_WORDS;
    op = tdata[idx][31:24];
    while (op != OP_END && idx < 64)
    begin
      arg = tdata[idx][23:0];
      case (op)
        OP_KBD:
        begin
          @(negedge CLK_50M);
          kbd_ascii = arg[7:0];
          kbd_ready = 1'b1;
          @(negedge CLK_50M);
          kbd_ready = 1'b0;
        end
        OP_KEYS:
        begin
          @(negedge CLK_50M);
          if (!arg[0])
            last_dir_up = 1'b1;
          if (!arg[1])
            last_dir_up = 1'b0;
          if (!arg[2])
            restore_seen = 1'b1;
          key = arg[2:0];
        end
        OP_WAIT:
          repeat (int'(arg)) @(negedge CLK_50M);
        OP_RATE:
        begin
          check_value("rate display", 32'(shown_rate()), {8'd0, arg});
          check_display(int'(arg));
        end
        OP_PLAY:
          check_value("ledr[0]", {31'd0, ledr[0]}, {31'd0, arg[0]});
        default:
        begin
          $display("ERROR: unknown script opcode %h at entry %0d", op, idx);
          other_errors++;
        end
      endcase
      idx++;
      if (idx < 64)
        op = tdata[idx][31:24];
    end

    // Playback has to have crossed both ends of the song
    if (!fwd_wrap_seen || !back_wrap_seen)
    begin
      $display("ERROR: playback never wrapped around the song in both directions");
      other_errors++;
    end

    $display("Errors: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/ipod_top.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_top (
  input wire logic CLK_50M,
  input wire logic arst_n,
  input wire logic [2:0] key,
  input wire ipod_pkg::ascii_t kbd_ascii,
  input wire logic kbd_ready,
  input wire logic flash_waitrequest,
  input wire ipod_pkg::flash_word_t flash_readdata,
  input wire logic flash_readdatavalid,
  output logic flash_read,
  output ipod_pkg::flash_addr_t flash_address,
  output ipod_pkg::sample_t sample,
  output logic sample_valid,
  output logic [9:0] ledr,
  output ipod_pkg::seg7_t hex0,
  output ipod_pkg::seg7_t hex1,
  output ipod_pkg::seg7_t hex2,
  output ipod_pkg::seg7_t hex3,
  output ipod_pkg::seg7_t hex4,
  output ipod_pkg::seg7_t hex5
);

  // Button pulses
  logic step_up;
  logic step_down;
  logic restore;

  // Rate
  ipod_pkg::rate_count_t rate_count;
  logic sample_tick;

  logic playing;

  // Word request channel
  flash_word_if fw_if ();

  // ====================
  // Rate path
  // ====================

  key_pacer u_key_pacer (
    .CLK_50M (CLK_50M),
    .arst_n (arst_n),
    .key (key),
    .step_up (step_up),
    .step_down (step_down),
    .restore (restore)
  );

  rate_control u_rate_control (
    .CLK_50M (CLK_50M),
    .arst_n (arst_n),
    .step_up (step_up),
    .step_down (step_down),
    .restore (restore),
    .rate_count (rate_count),
    .sample_tick (sample_tick)
  );

  hex_display u_hex_display (
    .CLK_50M (CLK_50M),
    .arst_n (arst_n),
    .rate_count (rate_count),
    .hex0 (hex0),
    .hex1 (hex1),
    .hex2 (hex2),
    .hex3 (hex3),
    .hex4 (hex4),
    .hex5 (hex5)
  );

  // ====================
  // Sample path
  // ====================

  playback_ctrl u_playback_ctrl (
    .CLK_50M (CLK_50M),
    .arst_n (arst_n),
    .kbd_ascii (kbd_ascii),
    .kbd_ready (kbd_ready),
    .sample_tick (sample_tick),
    .req (fw_if.requester),
    .sample (sample),
    .sample_valid (sample_valid),
    .playing (playing)
  );

  sample_fetch u_sample_fetch (
    .CLK_50M (CLK_50M),
    .arst_n (arst_n),
    .flash_waitrequest (flash_waitrequest),
    .flash_readdata (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .req (fw_if.fetcher),
    .flash_read (flash_read),
    .flash_address (flash_address)
  );

  level_meter u_level_meter (
    .CLK_50M (CLK_50M),
    .arst_n (arst_n),
    .sample (sample),
    .sample_valid (sample_valid),
    .playing (playing),
    .ledr (ledr)
  );

endmodule

`default_nettype wire

//--- logic/hex_display.sv
`timescale 1ns/1ps
`default_nettype none

module hex_display (
  input wire logic CLK_50M,
  input wire logic arst_n,
  input wire ipod_pkg::rate_count_t rate_count,
  output ipod_pkg::seg7_t hex0,
  output ipod_pkg::seg7_t hex1,
  output ipod_pkg::seg7_t hex2,
  output ipod_pkg::seg7_t hex3,
  output ipod_pkg::seg7_t hex4,
  output ipod_pkg::seg7_t hex5
);

  // Six nibbles, upper two always zero
  logic [23:0] shown;

  // Nibble to active-low segments, gfedcba
  function automatic ipod_pkg::seg7_t seg_decode(input logic [3:0] nib);
    case (nib)
      4'h0: seg_decode = 7'b1000000;
      4'h1: seg_decode = 7'b1111001;
      4'h2: seg_decode = 7'b0100100;
      4'h3: seg_decode = 7'b0110000;
      4'h4: seg_decode = 7'b0011001;
      4'h5: seg_decode = 7'b0010010;
      4'h6: seg_decode = 7'b0000010;
      4'h7: seg_decode = 7'b1111000;
      4'h8: seg_decode = 7'b0000000;
      4'h9: seg_decode = 7'b0010000;
      4'hA: seg_decode = 7'b0001000;
      4'hB: seg_decode = 7'b0000011;
      4'hC: seg_decode = 7'b1000110;
      4'hD: seg_decode = 7'b0100001;
      4'hE: seg_decode = 7'b0000110;
      default: seg_decode = 7'b0001110;
    endcase
  endfunction

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      shown <= 24'd0;
    else
      shown <= {8'd0, rate_count};
  end

  // hex0 is the lowest nibble
  assign hex0 = seg_decode(shown[3:0]);
  assign hex1 = seg_decode(shown[7:4]);
  assign hex2 = seg_decode(shown[11:8]);
  assign hex3 = seg_decode(shown[15:12]);
  assign hex4 = seg_decode(shown[19:16]);
  assign hex5 = seg_decode(shown[23:20]);

endmodule

`default_nettype wire

//--- logic/level_meter.sv
`timescale 1ns/1ps
`default_nettype none

module level_meter (
  input wire logic CLK_50M,
  input wire logic arst_n,
  input wire ipod_pkg::sample_t sample,
  input wire logic sample_valid,
  input wire logic playing,
  output logic [9:0] ledr
);

  // Magnitude, -128 comes out as 128
  logic [7:0] mag;
  logic [3:0] level;
  logic [8:0] bar;

  assign mag = sample[7] ? (~sample + 8'd1) : sample;
  // Zero to eight lit segments
  assign level = mag[7:4];
  // Thermometer from ledr[2] upward
  assign bar = (9'd1 << level) - 9'd1;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      ledr <= 10'd0;
    else
    begin
      if (sample_valid)
        ledr[9:2] <= bar[7:0];
      ledr[1] <= 1'b0;
      ledr[0] <= playing;
    end
  end

endmodule

`default_nettype wire

//--- logic/sample_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fetch (
  input wire logic CLK_50M,
  input wire logic arst_n,
  input wire logic flash_waitrequest,
  input wire ipod_pkg::flash_word_t flash_readdata,
  input wire logic flash_readdatavalid,
  flash_word_if.fetcher req,
  output logic flash_read,
  output ipod_pkg::flash_addr_t flash_address
);

  // Read issued and data not yet back
  logic busy;
  logic start;
  logic capture;

  assign start = !busy && req.req;
  assign capture = busy && !flash_read && flash_readdatavalid;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy <= 1'b0;
      flash_read <= 1'b0;
      req.done <= 1'b0;
    end
    else
    begin
      req.done <= capture;
      if (start)
      begin
        busy <= 1'b1;
        flash_read <= 1'b1;
      end
      // Read accepted once wait drops
      else if (flash_read && !flash_waitrequest)
        flash_read <= 1'b0;
      else if (capture)
        busy <= 1'b0;
    end
  end

  // Address and returned word
  always_ff @(posedge CLK_50M)
  begin
    if (start)
      flash_address <= req.addr;
    if (capture)
      req.word <= flash_readdata;
  end

endmodule

`default_nettype wire

//--- logic/playback_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module playback_ctrl (
  input wire logic CLK_50M,
  input wire logic arst_n,
  input wire ipod_pkg::ascii_t kbd_ascii,
  input wire logic kbd_ready,
  input wire logic sample_tick,
  flash_word_if.requester req,
  output ipod_pkg::sample_t sample,
  output logic sample_valid,
  output logic playing
);

  ipod_pkg::play_state_e state;
  ipod_pkg::flash_addr_t addr;
  ipod_pkg::flash_addr_t next_addr;
  ipod_pkg::flash_word_t word;

  // Direction, 1 is forward
  logic dir_fwd;

  // Request waiting to go out, request in flight
  logic launch;
  logic pending;

  // Decoded commands
  logic cmd_play;
  logic cmd_stop;
  logic cmd_fwd;
  logic cmd_back;
  logic cmd_restart;

  // Datapath events
  logic issue;
  logic take_word;
  logic emit_lo;
  logic emit_hi;

  assign cmd_play = kbd_ready && (kbd_ascii == ipod_pkg::CMD_PLAY);
  assign cmd_stop = kbd_ready && (kbd_ascii == ipod_pkg::CMD_STOP);
  assign cmd_fwd = kbd_ready && (kbd_ascii == ipod_pkg::CMD_FWD);
  assign cmd_back = kbd_ready && (kbd_ascii == ipod_pkg::CMD_BACK);
  assign cmd_restart = kbd_ready && (kbd_ascii == ipod_pkg::CMD_RESTART);

  // Only one request in flight
  assign issue = launch && !pending;

  // A word fetched before a restart is dropped
  assign take_word = req.done && (state == ipod_pkg::FETCH) && !launch;

  // Ticks with no sample ready fall through
  assign emit_lo = sample_tick && (state == ipod_pkg::PLAY_LO) && !cmd_stop;
  assign emit_hi = sample_tick && (state == ipod_pkg::PLAY_HI) && !cmd_stop;

  // Wrap at both ends of the song
  always_comb
  begin
    if (dir_fwd)
      next_addr = (addr == ipod_pkg::SONG_LAST_ADDR) ? '0 : addr + 23'd1;
    else
      next_addr = (addr == '0) ? ipod_pkg::SONG_LAST_ADDR : addr - 23'd1;
  end

  assign playing = (state != ipod_pkg::IDLE);

  // ====================
  // Control FSM
  // ====================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= ipod_pkg::IDLE;
      addr <= '0;
      dir_fwd <= 1'b1;
      launch <= 1'b0;
      pending <= 1'b0;
      req.req <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      req.req <= issue;
      sample_valid <= emit_lo | emit_hi;

      if (issue)
      begin
        launch <= 1'b0;
        pending <= 1'b1;
      end
      if (req.done)
        pending <= 1'b0;

      case (state)
        ipod_pkg::IDLE:
          if (cmd_play)
          begin
            state <= ipod_pkg::FETCH;
            launch <= 1'b1;
          end
        ipod_pkg::FETCH:
          if (take_word)
            state <= ipod_pkg::PLAY_LO;
        ipod_pkg::PLAY_LO:
          if (emit_lo)
            state <= ipod_pkg::PLAY_HI;
        ipod_pkg::PLAY_HI:
          if (emit_hi)
          begin
            // Next word goes out the cycle after
            state <= ipod_pkg::FETCH;
            launch <= 1'b1;
            addr <= next_addr;
          end
        default:
          state <= ipod_pkg::IDLE;
      endcase

      // Commands override the sequencing
      if (cmd_stop)
      begin
        state <= ipod_pkg::IDLE;
        launch <= 1'b0;
      end
      if (cmd_fwd)
        dir_fwd <= 1'b1;
      if (cmd_back)
        dir_fwd <= 1'b0;
      if (cmd_restart)
      begin
        addr <= '0;
        if (state != ipod_pkg::IDLE)
        begin
          state <= ipod_pkg::FETCH;
          launch <= 1'b1;
        end
      end
    end
  end

  // ====================
  // Word and sample data
  // ====================

  always_ff @(posedge CLK_50M)
  begin
    if (issue)
      req.addr <= addr;
    if (take_word)
      word <= req.word;
    // High byte of each 16-bit half
    if (emit_lo)
      sample <= word[15:8];
    if (emit_hi)
      sample <= word[31:24];
  end

endmodule

`default_nettype wire

//--- logic/rate_control.sv
`timescale 1ns/1ps
`default_nettype none

module rate_control (
  input wire logic CLK_50M,
  input wire logic arst_n,
  input wire logic step_up,
  input wire logic step_down,
  input wire logic restore,
  output ipod_pkg::rate_count_t rate_count,
  output logic sample_tick
);

  // Tick down-counter
  ipod_pkg::rate_count_t tick_cnt;

  // ====================
  // Divider count
  // ====================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      rate_count <= ipod_pkg::RATE_DEFAULT;
    else if (restore)
      rate_count <= ipod_pkg::RATE_DEFAULT;
    else if (step_up)
    begin
      // Faster, smaller count
      if (rate_count < ipod_pkg::RATE_MIN + ipod_pkg::RATE_STEP)
        rate_count <= ipod_pkg::RATE_MIN;
      else
        rate_count <= rate_count - ipod_pkg::RATE_STEP;
    end
    else if (step_down)
    begin
      // Slower, larger count
      if (rate_count > ipod_pkg::RATE_MAX - ipod_pkg::RATE_STEP)
        rate_count <= ipod_pkg::RATE_MAX;
      else
        rate_count <= rate_count + ipod_pkg::RATE_STEP;
    end
  end

  // ====================
  // Sample tick
  // ====================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tick_cnt <= ipod_pkg::RATE_DEFAULT;
      sample_tick <= 1'b0;
    end
    else if (tick_cnt == 16'd0)
    begin
      // Reload from the live count
      tick_cnt <= rate_count;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt <= tick_cnt - 16'd1;
      sample_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- logic/key_pacer.sv
`timescale 1ns/1ps
`default_nettype none

module key_pacer (
  input wire logic CLK_50M,
  input wire logic arst_n,
  input wire logic [2:0] key,
  output logic step_up,
  output logic step_down,
  output logic restore
);

  // Two-flop synchronizer, keys inverted so 1 means pressed
  logic [2:0] sync_a;
  logic [2:0] sync_b;

  // Previous restore level for edge detect
  logic restore_prev;

  // Free-running pacing counter
  logic [15:0] pace_cnt;
  logic pace_wrap;

  // Last count before wrap
  assign pace_wrap = (pace_cnt == ipod_pkg::PACE_CYCLES - 16'd1);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sync_a <= 3'b000;
      sync_b <= 3'b000;
      restore_prev <= 1'b0;
      pace_cnt <= 16'd0;
      step_up <= 1'b0;
      step_down <= 1'b0;
      restore <= 1'b0;
    end
    else
    begin
      // Synchronize the raw buttons
      sync_a <= ~key;
      sync_b <= sync_a;

      // Pacing counter
      if (pace_wrap)
        pace_cnt <= 16'd0;
      else
        pace_cnt <= pace_cnt + 16'd1;

      // One step per wrap while held
      step_up <= pace_wrap & sync_b[0];
      step_down <= pace_wrap & sync_b[1];

      // Restore fires once on press
      restore_prev <= sync_b[2];
      restore <= sync_b[2] & ~restore_prev;
    end
  end

endmodule

`default_nettype wire

//--- logic/flash_word_if.sv
`timescale 1ns/1ps
`default_nettype none

interface flash_word_if;

  // Request pulse, address held until done
  logic req;
  ipod_pkg::flash_addr_t addr;

  // Completion pulse, word valid in the same cycle
  logic done;
  ipod_pkg::flash_word_t word;

  // Playback side
  modport requester (
    output req,
    output addr,
    input done,
    input word
  );

  // Flash side
  modport fetcher (
    input req,
    input addr,
    output done,
    output word
  );

endinterface

`default_nettype wire

//--- logic/ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  // ====================
  // Data widths
  // ====================

  // Signed audio sample sent to the level meter
  typedef logic signed [7:0] sample_t;

  // One flash word, two packed 16-bit samples
  typedef logic [31:0] flash_word_t;

  // Flash word address
  typedef logic [22:0] flash_addr_t;

  // Sample divider, clock cycles per tick minus one
  typedef logic [15:0] rate_count_t;

  // Keyboard character
  typedef logic [7:0] ascii_t;

  // Active-low segments, bit 0 is segment a
  typedef logic [6:0] seg7_t;

  // Playback FSM states
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    PLAY_LO,
    PLAY_HI
  } play_state_e;

  // ====================
  // Rate and pacing
  // ====================

  // About 44 kHz at 50 MHz
  localparam rate_count_t RATE_DEFAULT = 16'd1136;
  localparam rate_count_t RATE_STEP = 16'd100;
  localparam rate_count_t RATE_MIN = 16'd236;
  localparam rate_count_t RATE_MAX = 16'd4036;

  // Cycles between repeated button steps
  localparam logic [15:0] PACE_CYCLES = 16'd3000;

  // Last word of the song
  localparam flash_addr_t SONG_LAST_ADDR = 23'd15;

  // ====================
  // Keyboard commands
  // ====================

  localparam ascii_t CMD_PLAY = 8'h45;
  localparam ascii_t CMD_STOP = 8'h44;
  localparam ascii_t CMD_FWD = 8'h46;
  localparam ascii_t CMD_BACK = 8'h42;
  localparam ascii_t CMD_RESTART = 8'h52;

endpackage

`default_nettype wire
